//--- sources.f
hw/uartRxPkg.sv
hw/baudTicker.sv
hw/uartReceiver.sv
hw/rxFifo.sv
hw/bistController.sv
hw/uartRxTop.sv
tb/uartRxTb.sv

//--- Makefile
# Verilator build for the UART receive subsystem testbench

SIM      := verilator
TOP      := uartRxTb
FILELIST := sources.f
OBJDIR   := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/100ps -Mdir $(OBJDIR)

SOURCES  := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation is the test result
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- tb/uartRxTb.sv
//////////////////////////////////////////////////
// UART receive subsystem testbench
// Serial driver, FIFO queue model, assertion checks
//////////////////////////////////////////////////
`default_nettype none

module uartRxTb;

	timeunit 1ns;
	timeprecision 100ps;

	import uartRxPkg::*;

	localparam int BaudDiv = 4;
	localparam int FifoDepthLog2 = 3;
	localparam int BistBytes = 4;
	localparam int Entries = 2 ** FifoDepthLog2;
	localparam int ClkPeriod = 8;
	localparam int DriveDelay = 1;
	localparam int BitCycles = OversampleRate * BaudDiv;
	localparam logic [31:0] LcgSeed = 32'h2958_b174;

	// Start confirm at mid bit, then nine sample periods up to the stop bit
	localparam int StopSample = (OversampleRate / 2 + 9 * OversampleRate) * BaudDiv;

	// Frames per test, they size the watchdog
	localparam int RandomFrames = 6;
	localparam int SweepPreload = 2;
	localparam int SweepMax = BaudDiv + 4;
	localparam int BistPreload = 3;
	localparam int BistNoise = 2;
	localparam int TotalFrames = RandomFrames + SweepPreload + SweepMax + 1 + (Entries + 1)
		+ BistPreload + BistNoise + BistBytes;
	localparam longint WatchdogTime = 2 * TotalFrames * 12 * BitCycles * ClkPeriod;

	logic Clk;
	logic rst;
	logic rxd;
	logic pop;
	logic bistStart;
	rxByte_t dataOut;
	fifoStatus_t status;
	logic frameError;
	logic bistDone;
	logic bistPass;

	rxByte_t modelQ [$];
	logic [8:0] sentQ [$];      // {low stop bit, byte} for frames on the line
	rxByte_t expData;
	logic expEmpty;
	logic expHalf;
	logic expOverflow;
	logic bistRunning;
	logic passHeld;
	logic expActive;
	logic expPass;
	int frameErrCount;
	int bothCount;              // Cycles where a write met a pop
	logic [31:0] lcgState;

	uartRxTop #(
		.BaudDiv(BaudDiv),
		.FifoDepthLog2(FifoDepthLog2),
		.BistBytes(BistBytes)
	) dut_i (
		.Clk(Clk),
		.rst(rst),
		.rxd(rxd),
		.pop(pop),
		.bistStart(bistStart),
		.dataOut(dataOut),
		.status(status),
		.frameError(frameError),
		.bistDone(bistDone),
		.bistPass(bistPass)
	);

	initial
	begin
		Clk = 1'b0;
		forever #(ClkPeriod / 2) Clk = ~Clk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	task automatic flagMismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		$display("[FAIL] %s expected 0x%02h got 0x%02h", name, expected, actual);
		$display("Test failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic abortRun(input string reason);
		$display("Error: %s", reason);
		$display("Test failed");
		$fatal(1, "run aborted");
	endtask

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic rxByte_t randomByte();
		logic [31:0] value;
		value = nextRandom();
		return value[23:16];    // Upper bits, better spread
	endfunction

	// Each step ends just after a rising edge
	task automatic stepCycles(input int n);
		repeat (n)
		begin
			@(posedge Clk);
			#DriveDelay;
		end
	endtask

	// 8N1 frame plus one idle bit, LSB first
	task automatic sendFrame(input rxByte_t value, input logic goodStop, input logic tracked);
		int b;
		if (tracked)
			sentQ.push_back({!goodStop, value});
		rxd = 1'b0;
		stepCycles(BitCycles);
		for (b = 0; b < 8; b++)
		begin
			rxd = value[b];
			stepCycles(BitCycles);
		end
		rxd = goodStop;
		stepCycles(BitCycles);
		rxd = 1'b1;
		stepCycles(BitCycles);
	endtask

	task automatic popByte(input int gap);
		pop = 1'b1;
		stepCycles(1);
		pop = 1'b0;
		stepCycles(gap);
	endtask

	task automatic waitRxIdle();
		while (sentQ.size() != 0)
			stepCycles(1);
	endtask

	task automatic drainFifo();
		while (modelQ.size() != 0)
			popByte(nextRandom() % 4);
		popByte(1);             // Pop on empty, ignored
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	assign expActive = bistRunning && !bistDone;   // Falls with the done pulse
	assign expPass = bistDone || passHeld;

	always @(posedge Clk)
	begin
		logic [8:0] frame;
		logic writeTaken;
		logic popTaken;
		logic ovfNext;
		writeTaken = 1'b0;
		frame = '0;
		ovfNext = expOverflow;
		if (rst)
		begin
			modelQ.delete();
			sentQ.delete();
			expData <= '0;
			expEmpty <= 1'b1;
			expHalf <= 1'b0;
			expOverflow <= 1'b0;
			bistRunning <= 1'b0;
			passHeld <= 1'b0;
			frameErrCount <= 0;
			bothCount <= 0;
		end
		else
		begin
			// BIST frames are checked inside the DUT
			if (!expActive && (dut_i.rxEvent.dataRdy || frameError))
			begin
				if (sentQ.size() == 0)
					abortRun("receiver reported a frame that was never sent");
				else
				begin
					frame = sentQ.pop_front();
					if (frameError)
					begin
						assert (frame[8])
							else abortRun("frameError on a frame with a good stop bit");
						frameErrCount <= frameErrCount + 1;
					end
					else
					begin
						assert (!frame[8])
							else abortRun("byte accepted from a frame with a low stop bit");
						assert (dut_i.rxEvent.data == frame[7:0])
							else flagMismatch("rxEvent.data", frame[7:0], dut_i.rxEvent.data);
						writeTaken = 1'b1;
					end
				end
			end

			popTaken = pop && !expActive && (modelQ.size() != 0);
			if (popTaken)
			begin
				expData <= modelQ.pop_front();
				ovfNext = 1'b0;
			end
			if (writeTaken)
			begin
				if (modelQ.size() < Entries)
					modelQ.push_back(frame[7:0]);
				else
					ovfNext = 1'b1;     // Full, byte lost
				if (popTaken)
					bothCount <= bothCount + 1;
			end
			expEmpty <= (modelQ.size() == 0);
			expHalf <= (modelQ.size() >= Entries / 2);
			expOverflow <= ovfNext;

			if (bistStart && !bistRunning)
			begin
				bistRunning <= 1'b1;
				passHeld <= 1'b0;
			end
			else if (bistDone)
			begin
				bistRunning <= 1'b0;
				passHeld <= 1'b1;   // Clean loopback must pass
			end
		end
	end

	//////////////////////////////////////////////////
	// Output checks
	//////////////////////////////////////////////////
	assert property (@(posedge Clk) disable iff (rst) status.empty == expEmpty)
		else flagMismatch("status.empty", $sampled(expEmpty), $sampled(status.empty));

	assert property (@(posedge Clk) disable iff (rst) status.halfFull == expHalf)
		else flagMismatch("status.halfFull", $sampled(expHalf), $sampled(status.halfFull));

	assert property (@(posedge Clk) disable iff (rst) status.overflow == expOverflow)
		else flagMismatch("status.overflow", $sampled(expOverflow), $sampled(status.overflow));

	assert property (@(posedge Clk) disable iff (rst) dataOut == expData)
		else flagMismatch("dataOut", $sampled(expData), $sampled(dataOut));

	assert property (@(posedge Clk) disable iff (rst) bistPass == expPass)
		else flagMismatch("bistPass", $sampled(expPass), $sampled(bistPass));

	assert property (@(posedge Clk) disable iff (rst) dut_i.bistActive == expActive)
		else flagMismatch("bistActive", $sampled(expActive), $sampled(dut_i.bistActive));

	assert property (@(posedge Clk) disable iff (rst) bistDone |=> !bistDone)
		else abortRun("bistDone stayed high for more than one cycle");

	// Done only ever ends a running self-test
	assert property (@(posedge Clk) disable iff (rst) bistDone |-> bistRunning)
		else abortRun("bistDone pulsed with no self-test running");

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial
	begin
		int i;
		int errBefore;
		lcgState = LcgSeed;
		rst = 1'b1;
		rxd = 1'b1;
		pop = 1'b0;
		bistStart = 1'b0;
		repeat (4) @(posedge Clk);
		#DriveDelay;
		rst = 1'b0;
		stepCycles(2 * BitCycles);

		// Random bytes, popped in order
		for (i = 0; i < RandomFrames; i++)
			sendFrame(randomByte(), 1'b1, 1'b1);
		waitRxIdle();
		drainFifo();

		// Frames are a whole number of ticks long, so the pop sweep hits the write
		for (i = 0; i < SweepPreload; i++)
			sendFrame(randomByte(), 1'b1, 1'b1);
		i = 0;
		while ((bothCount == 0) && (i < SweepMax))
		begin
			fork
				sendFrame(randomByte(), 1'b1, 1'b1);
				begin
					stepCycles(StopSample + i);
					popByte(0);
				end
			join
			i++;
		end
		assert (bothCount != 0) else abortRun("no pop ever landed on a FIFO write");
		drainFifo();

		// Low stop bit
		errBefore = frameErrCount;
		sendFrame(randomByte(), 1'b0, 1'b1);
		waitRxIdle();
		assert (frameErrCount == errBefore + 1)
			else abortRun("frame with a low stop bit gave no frameError");

		// One byte past full
		for (i = 0; i <= Entries; i++)
			sendFrame(randomByte(), 1'b1, 1'b1);
		waitRxIdle();
		assert (status.overflow === 1'b1)
			else flagMismatch("status.overflow", 8'h01, status.overflow);
		popByte(2);
		assert (status.overflow === 1'b0)
			else flagMismatch("status.overflow", 8'h00, status.overflow);
		drainFifo();

		// BIST with bytes stored, rxd traffic and pops ignored
		for (i = 0; i < BistPreload; i++)
			sendFrame(randomByte(), 1'b1, 1'b1);
		waitRxIdle();
		bistStart = 1'b1;
		stepCycles(1);
		bistStart = 1'b0;
		stepCycles(2);
		for (i = 0; i < BistNoise; i++)
		begin
			sendFrame(randomByte(), 1'b1, 1'b0);
			popByte(1);
		end
		while (bistDone !== 1'b1)
			stepCycles(1);
		assert (bistPass === 1'b1) else flagMismatch("bistPass", 8'h01, bistPass);
		stepCycles(4);
		drainFifo();

		$display("Test passed");
		$finish;
	end

	// Twice the serial time of every frame in the run
	initial
	begin
		#(WatchdogTime);
		abortRun("watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

//--- hw/uartRxTop.sv
//////////////////////////////////////////////////
// UART receive subsystem top
// Ticker, receiver, FIFO and BIST with loopback mux
//////////////////////////////////////////////////
`default_nettype none

module uartRxTop #(
	parameter int BaudDiv = 27,
	parameter int FifoDepthLog2 = 4,
	parameter int BistBytes = 8
) (
	input logic Clk,
	input logic rst,
	input logic rxd,
	input logic pop,
	input logic bistStart,
	output uartRxPkg::rxByte_t dataOut,
	output uartRxPkg::fifoStatus_t status,
	output logic frameError,
	output logic bistDone,
	output logic bistPass
);

	import uartRxPkg::*;

	logic tick;
	logic bistActive;
	logic bistTxd;
	logic serialIn;
	rxEvent_t rxEvent;

	// BIST owns the receiver input while it runs
	assign serialIn = bistActive ? bistTxd : rxd;
	assign frameError = rxEvent.frameError;

	baudTicker #(
		.BaudDiv(BaudDiv)
	) ticker_i (
		.Clk(Clk),
		.rst(rst),
		.tick(tick)
	);

	uartReceiver receiver_i (
		.Clk(Clk),
		.rst(rst),
		.tick(tick),
		.rxd(serialIn),
		.rxEvent(rxEvent)
	);

	rxFifo #(
		.FifoDepthLog2(FifoDepthLog2)
	) fifo_i (
		.Clk(Clk),
		.rst(rst),
		.rxEvent(rxEvent),
		.pop(pop),
		.bistActive(bistActive),
		.dataOut(dataOut),
		.status(status)
	);

	bistController #(
		.BistBytes(BistBytes)
	) bist_i (
		.Clk(Clk),
		.rst(rst),
		.tick(tick),
		.bistStart(bistStart),
		.rxEvent(rxEvent),
		.bistActive(bistActive),
		.bistTxd(bistTxd),
		.bistDone(bistDone),
		.bistPass(bistPass)
	);

endmodule

`default_nettype wire

//--- hw/bistController.sv
//////////////////////////////////////////////////
// BIST controller
// Loops LFSR frames through the receiver and checks them
//////////////////////////////////////////////////
`default_nettype none

module bistController #(
	parameter int BistBytes = 8
) (
	input logic Clk,
	input logic rst,
	input logic tick,
	input logic bistStart,
	input uartRxPkg::rxEvent_t rxEvent,
	output logic bistActive,
	output logic bistTxd,
	output logic bistDone,
	output logic bistPass
);

	import uartRxPkg::*;

	localparam int CntWidth = $clog2(BistBytes + 1);
	localparam logic [7:0] Seed = 8'hA5;
	localparam logic [3:0] LastCount = 4'(OversampleRate - 1);
	localparam logic [3:0] FrameBits = 4'd12;    // start, 8 data, stop, 2 idle
	localparam logic [CntWidth-1:0] ByteTotal = CntWidth'(BistBytes);
	localparam logic [CntWidth-1:0] LastByte = CntWidth'(BistBytes - 1);

	bistState_t state;
	rxByte_t txLfsr;
	rxByte_t chkLfsr;
	logic [9:0] txShift;        // LSB is the line
	logic [3:0] osCount;
	logic [3:0] bitCnt;
	logic [CntWidth-1:0] txCount;
	logic [CntWidth-1:0] rxCount;
	logic passFlag;
	logic startTest;
	logic frameEnd;
	logic rxSeen;

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic rxByte_t lfsrNext(input rxByte_t value);
		return {value[6:0], value[7] ^ value[5] ^ value[4] ^ value[3]};
	endfunction

	assign bistTxd = txShift[0];
	assign startTest = (state == bistIdle) && bistStart;
	assign frameEnd = tick && (osCount == LastCount) && (bitCnt == FrameBits - 1'b1);
	assign rxSeen = bistActive && (rxEvent.dataRdy || rxEvent.frameError);

	//////////////////////////////////////////////////
	// Sequencer and serializer
	//////////////////////////////////////////////////
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			state <= bistIdle;
			bistActive <= 1'b0;
			bistDone <= 1'b0;
			bistPass <= 1'b0;
			txShift <= '1;
			osCount <= '0;
			bitCnt <= '0;
			txCount <= '0;
		end
		else
		begin
			bistDone <= 1'b0;
			case (state)
				bistIdle:
				begin
					if (bistStart)
					begin
						state <= bistSend;
						bistActive <= 1'b1;
						bistPass <= 1'b0;
						txShift <= {1'b1, Seed, 1'b0};
						txLfsr <= lfsrNext(Seed);
						osCount <= '0;
						bitCnt <= '0;
						txCount <= '0;
					end
				end
				bistSend:
				begin
					if (tick)
					begin
						osCount <= osCount + 1'b1;
						if (osCount == LastCount)
						begin
							txShift <= {1'b1, txShift[9:1]};   // Ones fill the gap
							bitCnt <= bitCnt + 1'b1;
						end
					end
					if (frameEnd)
					begin
						bitCnt <= '0;
						txCount <= txCount + 1'b1;
						if (txCount == LastByte)
							state <= bistWait;
						else
						begin
							txShift <= {1'b1, txLfsr, 1'b0};
							txLfsr <= lfsrNext(txLfsr);
						end
					end
				end
				bistWait:
				begin
					// Give up after one frame time without the last byte
					if (tick)
					begin
						osCount <= osCount + 1'b1;
						if (osCount == LastCount)
							bitCnt <= bitCnt + 1'b1;
					end
					if ((rxCount == ByteTotal) || (bitCnt == FrameBits))
					begin
						state <= uartRxPkg::bistDone;
						bistActive <= 1'b0;
						bistDone <= 1'b1;
						bistPass <= passFlag && (rxCount == ByteTotal);
					end
				end
				uartRxPkg::bistDone: state <= bistIdle;
				default: state <= bistIdle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Checker
	//////////////////////////////////////////////////
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			passFlag <= 1'b0;
			rxCount <= '0;
		end
		else if (startTest)
		begin
			passFlag <= 1'b1;
			rxCount <= '0;
			chkLfsr <= Seed;
		end
		else if (rxSeen)
		begin
			if (rxCount == ByteTotal)
				passFlag <= 1'b0;        // More bytes than were sent
			else
				rxCount <= rxCount + 1'b1;
			if (rxEvent.frameError || (rxEvent.data != chkLfsr))
				passFlag <= 1'b0;
			chkLfsr <= lfsrNext(chkLfsr);
		end
	end

	// Loopback line must idle high whenever no frame is being sent
	assert property (@(posedge Clk) disable iff (rst) (state != bistSend) |-> bistTxd)
		else $error("bistTxd low outside bistSend");

endmodule

`default_nettype wire

//--- hw/rxFifo.sv
//////////////////////////////////////////////////
// Receive FIFO
// Empty, half-full and sticky overflow, frozen in BIST
//////////////////////////////////////////////////
`default_nettype none

module rxFifo #(
	parameter int FifoDepthLog2 = 4
) (
	input logic Clk,
	input logic rst,
	input uartRxPkg::rxEvent_t rxEvent,
	input logic pop,
	input logic bistActive,
	output uartRxPkg::rxByte_t dataOut,
	output uartRxPkg::fifoStatus_t status
);

	import uartRxPkg::*;

	localparam int Entries = 2 ** FifoDepthLog2;
	localparam logic [FifoDepthLog2:0] FullCount = (FifoDepthLog2 + 1)'(Entries);
	localparam logic [FifoDepthLog2:0] HalfCount = (FifoDepthLog2 + 1)'(Entries / 2);

	rxByte_t storage [Entries];
	logic [FifoDepthLog2-1:0] wrPtr;
	logic [FifoDepthLog2-1:0] rdPtr;
	logic [FifoDepthLog2:0] count;
	logic [FifoDepthLog2:0] nextCount;
	logic isFull;
	logic doPop;
	logic doWrite;
	logic dropWrite;

	assign isFull = (count == FullCount);
	assign doPop = pop && !bistActive && (count != '0);

	// A pop in the same cycle frees the slot, so a full FIFO still takes the byte
	assign doWrite = rxEvent.dataRdy && !bistActive && (!isFull || doPop);
	assign dropWrite = rxEvent.dataRdy && !bistActive && isFull && !doPop;

	always_comb
	begin
		case ({doWrite, doPop})
			2'b10: nextCount = count + 1'b1;
			2'b01: nextCount = count - 1'b1;
			default: nextCount = count;      // Idle or write with pop
		endcase
	end

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////
	always_ff @(posedge Clk)
	begin
		if (doWrite)
			storage[wrPtr] <= rxEvent.data;
	end

	//////////////////////////////////////////////////
	// Pointers, count and flags
	//////////////////////////////////////////////////
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			dataOut <= '0;
			status.empty <= 1'b1;
			status.halfFull <= 1'b0;
			status.overflow <= 1'b0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
			begin
				dataOut <= storage[rdPtr];   // Holds until the next pop
				rdPtr <= rdPtr + 1'b1;
			end
			count <= nextCount;
			status.empty <= (nextCount == '0);
			status.halfFull <= (nextCount >= HalfCount);

			// Lost byte stays flagged until the reader catches up
			if (doPop)
				status.overflow <= 1'b0;
			else if (dropWrite)
				status.overflow <= 1'b1;
		end
	end

	assert property (@(posedge Clk) disable iff (rst) count <= FullCount)
		else $error("FIFO count above capacity");

	assert property (@(posedge Clk) disable iff (rst) !(status.empty && status.halfFull))
		else $error("empty and halfFull high together");

endmodule

`default_nettype wire

//--- hw/uartReceiver.sv
//////////////////////////////////////////////////
// UART 8N1 receiver
// Oversampled start detect, LSB first data, stop check
//////////////////////////////////////////////////
`default_nettype none

module uartReceiver (
	input logic Clk,
	input logic rst,
	input logic tick,
	input logic rxd,
	output uartRxPkg::rxEvent_t rxEvent
);

	import uartRxPkg::*;

	localparam logic [3:0] MidCount = 4'(OversampleRate / 2 - 1);
	localparam logic [3:0] LastCount = 4'(OversampleRate - 1);

	rxState_t state;
	logic rxMeta;
	logic rxSync;
	logic waitHigh;          // Set after a framing error
	logic [3:0] osCount;
	logic [2:0] bitCnt;
	rxByte_t shiftReg;

	// Two-stage synchronizer, idles high like the line
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end
		else
		begin
			rxMeta <= rxd;
			rxSync <= rxMeta;
		end
	end

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			state <= rxIdle;
			waitHigh <= 1'b0;
			osCount <= '0;
			bitCnt <= '0;
			rxEvent.dataRdy <= 1'b0;
			rxEvent.frameError <= 1'b0;
		end
		else
		begin
			rxEvent.dataRdy <= 1'b0;
			rxEvent.frameError <= 1'b0;
			if (tick)
			begin
				case (state)
					rxIdle:
					begin
						osCount <= '0;
						if (rxSync)
							waitHigh <= 1'b0;   // Line recovered
						else if (!waitHigh)
							state <= rxStart;   // Falling edge seen
					end
					rxStart:
					begin
						if (osCount == MidCount)
						begin
							// Middle of start bit, reject glitches
							osCount <= '0;
							bitCnt <= '0;
							state <= rxSync ? rxIdle : rxData;
						end
						else
							osCount <= osCount + 1'b1;
					end
					rxData:
					begin
						osCount <= osCount + 1'b1;     // Wraps every bit
						if (osCount == LastCount)
						begin
							shiftReg <= {rxSync, shiftReg[7:1]};   // LSB first
							bitCnt <= bitCnt + 1'b1;
							if (bitCnt == 3'd7)
								state <= rxStop;
						end
					end
					rxStop:
					begin
						osCount <= osCount + 1'b1;
						if (osCount == LastCount)
						begin
							rxEvent.dataRdy <= rxSync;
							rxEvent.frameError <= !rxSync;
							rxEvent.data <= shiftReg;
							waitHigh <= !rxSync;
							state <= rxIdle;
						end
					end
					default: state <= rxIdle;
				endcase
			end
		end
	end

	// Each frame ends in exactly one kind of event
	assert property (@(posedge Clk) disable iff (rst)
		!(rxEvent.dataRdy && rxEvent.frameError))
		else $error("dataRdy and frameError high together");

endmodule

`default_nettype wire

//--- hw/baudTicker.sv
//////////////////////////////////////////////////
// Baud ticker
// Single-cycle pulse every BaudDiv clocks (16x bit rate)
//////////////////////////////////////////////////
`default_nettype none

module baudTicker #(
	parameter int BaudDiv = 27
) (
	input logic Clk,
	input logic rst,
	output logic tick
);

	localparam int CntWidth = (BaudDiv > 1) ? $clog2(BaudDiv) : 1;
	localparam logic [CntWidth-1:0] Reload = CntWidth'(BaudDiv - 1);

	logic [CntWidth-1:0] count;

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			count <= Reload;
			tick <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= Reload;
			tick <= 1'b1;      // Pulse on reload
		end
		else
		begin
			count <= count - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/uartRxPkg.sv
//////////////////////////////////////////////////
// UART receive subsystem shared types
// Byte, event and status structs plus FSM states
//////////////////////////////////////////////////
`default_nettype none

package uartRxPkg;

	// Ticks per serial bit
	localparam int OversampleRate = 16;

	// Fixed 8N1 frame, so one byte per frame
	typedef logic [7:0] rxByte_t;

	typedef struct packed {
		logic    dataRdy;     // Good byte, one cycle
		logic    frameError;  // Stop bit was low, one cycle
		rxByte_t data;
	} rxEvent_t;

	typedef struct packed {
		logic empty;
		logic halfFull;
		logic overflow;       // Sticky until next pop
	} fifoStatus_t;

	typedef enum logic [1:0] {
		rxIdle,
		rxStart,
		rxData,
		rxStop
	} rxState_t;

	typedef enum logic [1:0] {
		bistIdle,
		bistSend,
		bistWait,
		bistDone
	} bistState_t;

endpackage

`default_nettype wire
